/* mipsPkg.sv */
//----------------------------------------------------------------------
// MIPS core package
// Opcodes, function codes, ALU operations and the instruction word
//----------------------------------------------------------------------

package mipsPkg;

    // Major opcodes handled by the core
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0A,
        OpAndi    = 6'h0C,
        OpOri     = 6'h0D,
        OpXori    = 6'h0E,
        OpLui     = 6'h0F
    } opcodeT;

    // R-type function codes, SPECIAL opcode only
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnSra  = 6'h03,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2A,
        FnSltu = 6'h2B
    } functT;

    // ALU operation select
    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
        AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
    } aluOpT;

    //------------------------------------------------------------------
    // Instruction word, same 32 bits seen as R-type or I-type
    //------------------------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT       r;
        iTypeT       i;
        logic [31:0] raw;
    } instrT;

endpackage

/* registers.sv */
//----------------------------------------------------------------------
// Register file
// Hard-wired zero plus writable registers, three read ports, one write
//----------------------------------------------------------------------

`timescale 1ns/1ps

module registers #(
    parameter int DataWidth = 32,
    parameter int RegCount  = 32,
    localparam int AddrWidth = $clog2(RegCount)
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic                 RegWrite,
    input  logic [AddrWidth-1:0] RdAddr,
    input  logic [AddrWidth-1:0] RsAddr,
    input  logic [AddrWidth-1:0] RtAddr,
    input  logic [AddrWidth-1:0] RegAddr,
    input  logic [DataWidth-1:0] RdData,
    output logic [DataWidth-1:0] RsData,
    output logic [DataWidth-1:0] RtData,
    output logic [DataWidth-1:0] RegData
);

    // Entry 0 has no storage, it always reads as zero
    logic [DataWidth-1:0] regFile [1:RegCount-1];

    //------------------------------------------------------------------
    // Write port
    //------------------------------------------------------------------
    // Whole file clears on reset
    // Writes to address 0 are dropped
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            for (int k = 1; k < RegCount; k++)
                regFile[k] <= '0;
        end
        else if (RegWrite && RdAddr != '0)
        begin
            regFile[RdAddr] <= RdData;
        end
    end

    //------------------------------------------------------------------
    // Read ports, asynchronous
    //------------------------------------------------------------------
    // Operand ports feed the ALU, debug port goes to the top level
    assign RsData  = (RsAddr  == '0) ? '0 : regFile[RsAddr];
    assign RtData  = (RtAddr  == '0) ? '0 : regFile[RtAddr];
    assign RegData = (RegAddr == '0) ? '0 : regFile[RegAddr];

    // Decoder must hand over a clean destination on every write
    writeAddrKnown: assert property (
        @(posedge Clock) disable iff (!nReset)
        RegWrite |-> !$isunknown(RdAddr))
        else $error("registers: write with unknown RdAddr");

endmodule

/* instrDecode.sv */
//----------------------------------------------------------------------
// Instruction decoder
// Register addresses, ALU operation, immediate and write control
//----------------------------------------------------------------------

`timescale 1ns/1ps

module instrDecode import mipsPkg::*; (
    input  instrT       Instr,
    input  logic        InstrValid,
    output logic [4:0]  RsAddr,
    output logic [4:0]  RtAddr,
    output logic [4:0]  RdAddr,
    output logic        RegWrite,
    output logic        UseImm,
    output logic        Illegal,
    output aluOpT       AluOp,
    output logic [4:0]  Shamt,
    output logic [31:0] Imm
);

    logic isRType;
    logic legal;
    logic zeroExt;

    // SPECIAL selects the R-type view of the word
    assign isRType = (Instr.r.opcode == OpSpecial);

    // Source fields sit at the same bits in both views
    assign RsAddr = Instr.r.rs;
    assign RtAddr = Instr.r.rt;
    // Destination is rd for R-type, rt for I-type
    assign RdAddr = isRType ? Instr.r.rd : Instr.i.rt;
    assign Shamt  = Instr.r.shamt;

    //------------------------------------------------------------------
    // Operation decode
    //------------------------------------------------------------------
    always_comb
    begin
        AluOp   = AluAdd;
        UseImm  = 1'b0;
        zeroExt = 1'b0;
        legal   = 1'b1;
        if (isRType)
        begin
            // Function code picks the operation
            case (Instr.r.funct)
                FnAddu:  AluOp = AluAdd;
                FnSubu:  AluOp = AluSub;
                FnAnd:   AluOp = AluAnd;
                FnOr:    AluOp = AluOr;
                FnXor:   AluOp = AluXor;
                FnNor:   AluOp = AluNor;
                FnSlt:   AluOp = AluSlt;
                FnSltu:  AluOp = AluSltu;
                FnSll:   AluOp = AluSll;
                FnSrl:   AluOp = AluSrl;
                FnSra:   AluOp = AluSra;
                default: legal = 1'b0;
            endcase
        end
        else
        begin
            // Every I-type takes its second operand from the immediate
            UseImm = 1'b1;
            case (Instr.i.opcode)
                OpAddiu: AluOp = AluAdd;
                OpSlti:  AluOp = AluSlt;
                OpAndi:
                begin
                    AluOp   = AluAnd;
                    zeroExt = 1'b1;
                end
                OpOri:
                begin
                    AluOp   = AluOr;
                    zeroExt = 1'b1;
                end
                OpXori:
                begin
                    AluOp   = AluXor;
                    zeroExt = 1'b1;
                end
                // Shifted into the upper half by the ALU
                OpLui:
                begin
                    AluOp   = AluLui;
                    zeroExt = 1'b1;
                end
                default: legal = 1'b0;
            endcase
        end
    end

    // Logic ops and LUI zero-extend, arithmetic and compare sign-extend
    assign Imm = zeroExt ? {16'b0, Instr.i.imm}
                         : {{16{Instr.i.imm[15]}}, Instr.i.imm};

    // Both flags only count for a valid instruction
    always_comb
    begin
        RegWrite = InstrValid && legal;
        Illegal  = InstrValid && !legal;
    end

endmodule

/* alu.sv */
//----------------------------------------------------------------------
// ALU
// Combinational add, subtract, logic, compare and shift
//----------------------------------------------------------------------

`timescale 1ns/1ps

module alu import mipsPkg::*; #(
    parameter int DataWidth = 32
) (
    input  aluOpT                AluOp,
    input  logic [DataWidth-1:0] A,
    input  logic [DataWidth-1:0] B,
    input  logic [4:0]           Shamt,
    output logic [DataWidth-1:0] Result
);

    logic ltSigned;
    logic ltUnsigned;

    // Compare flags, widened to a 0 or 1 result below
    assign ltSigned   = $signed(A) < $signed(B);
    assign ltUnsigned = A < B;

    //------------------------------------------------------------------
    // Operation select
    //------------------------------------------------------------------
    always_comb
    begin
        knownOp: assert (AluOp <= AluLui)
            else $error("alu: undefined operation %0d", AluOp);
        case (AluOp)
            // Wrap-around, no overflow trap
            AluAdd:  Result = A + B;
            AluSub:  Result = A - B;
            AluAnd:  Result = A & B;
            AluOr:   Result = A | B;
            AluXor:  Result = A ^ B;
            AluNor:  Result = ~(A | B);
            AluSlt:  Result = DataWidth'(ltSigned);
            AluSltu: Result = DataWidth'(ltUnsigned);
            // Shifts act on the second operand
            AluSll:  Result = B << Shamt;
            AluSrl:  Result = B >> Shamt;
            AluSra:  Result = $unsigned($signed(B) >>> Shamt);
            // Immediate lands in the upper half
            AluLui:  Result = B << 16;
            default: Result = '0;
        endcase
    end

endmodule

/* mipsCore.sv */
//----------------------------------------------------------------------
// MIPS execute core, one instruction per clock
//----------------------------------------------------------------------

`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
    parameter int DataWidth = 32,
    parameter int RegCount  = 32
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  instrT                Instr,
    input  logic                 InstrValid,
    input  logic [4:0]           DbgAddr,
    output logic [DataWidth-1:0] DbgData,
    output logic                 Illegal
);

    localparam int AddrWidth = $clog2(RegCount);

    logic [4:0]           rsAddr;
    logic [4:0]           rtAddr;
    logic [4:0]           rdAddr;
    logic                 regWrite;
    logic                 useImm;
    aluOpT                aluOp;
    logic [4:0]           shamt;
    logic [31:0]          imm;
    logic [DataWidth-1:0] rsData;
    logic [DataWidth-1:0] rtData;
    logic [DataWidth-1:0] operandB;
    logic [DataWidth-1:0] result;

    instrDecode decoder (
        .Instr      (Instr),
        .InstrValid (InstrValid),
        .RsAddr     (rsAddr),
        .RtAddr     (rtAddr),
        .RdAddr     (rdAddr),
        .RegWrite   (regWrite),
        .UseImm     (useImm),
        .Illegal    (Illegal),
        .AluOp      (aluOp),
        .Shamt      (shamt),
        .Imm        (imm)
    );

    // Address fields trimmed to the register file size
    registers #(
        .DataWidth (DataWidth),
        .RegCount  (RegCount)
    ) regs (
        .Clock    (Clock),
        .nReset   (nReset),
        .RegWrite (regWrite),
        .RdAddr   (rdAddr[AddrWidth-1:0]),
        .RsAddr   (rsAddr[AddrWidth-1:0]),
        .RtAddr   (rtAddr[AddrWidth-1:0]),
        .RegAddr  (DbgAddr[AddrWidth-1:0]),
        .RdData   (result),
        .RsData   (rsData),
        .RtData   (rtData),
        .RegData  (DbgData)
    );

    // Operand B mux, immediate sign-extended to the datapath width
    assign operandB = useImm ? DataWidth'(signed'(imm)) : rtData;

    alu #(
        .DataWidth (DataWidth)
    ) execUnit (
        .AluOp  (aluOp),
        .A      (rsData),
        .B      (operandB),
        .Shamt  (shamt),
        .Result (result)
    );

endmodule

/* mipsCore_tb.sv */
//----------------------------------------------------------------------
// MIPS core testbench
// Instruction table in a loop, register model, debug port checks
//----------------------------------------------------------------------

`timescale 1ns/1ps

module mipsCore_tb import mipsPkg::*;;

    logic        Clock;
    logic        nReset;
    instrT       Instr;
    logic        InstrValid;
    logic [4:0]  DbgAddr;
    logic [31:0] DbgData;
    logic        Illegal;

    int          errors;
    logic [31:0] model [32];
    logic [31:0] instrQ [$];
    logic        validQ [$];
    logic        illegalQ [$];

    mipsCore uut (
        .Clock      (Clock),
        .nReset     (nReset),
        .Instr      (Instr),
        .InstrValid (InstrValid),
        .DbgAddr    (DbgAddr),
        .DbgData    (DbgData),
        .Illegal    (Illegal)
    );

    // 100 ns clock
    initial
    begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // Reset low for 4 cycles
    initial
    begin
        nReset = 1'b0;
        repeat (4) @(posedge Clock);
        #5 nReset = 1'b1;
    end

    //------------------------------------------------------------------
    // Instruction encoding through the union views
    //------------------------------------------------------------------
    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [4:0] sh,
                                            input logic [5:0] fn);
        instrT w;
        w.r.opcode = OpSpecial;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = sh;
        w.r.funct  = fn;
        return w.raw;
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        instrT w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w.raw;
    endfunction

    task automatic addEntry(input logic [31:0] w, input logic v, input logic ill);
        instrQ.push_back(w);
        validQ.push_back(v);
        illegalQ.push_back(ill);
    endtask

    // Word, valid, expected Illegal
    task automatic buildTable;
        addEntry(encodeI(OpOri, 5'd0, 5'd1, 16'h1234), 1'b1, 1'b0);
        addEntry(encodeI(OpLui, 5'd0, 5'd2, 16'h8000), 1'b1, 1'b0);
        addEntry(encodeI(OpOri, 5'd2, 5'd2, 16'h0001), 1'b1, 1'b0);
        // Negative immediates sign-extend
        addEntry(encodeI(OpAddiu, 5'd0, 5'd3, 16'hFFFF), 1'b1, 1'b0);
        addEntry(encodeI(OpAddiu, 5'd1, 5'd4, 16'h8000), 1'b1, 1'b0);
        addEntry(encodeI(OpSlti, 5'd3, 5'd13, 16'h0000), 1'b1, 1'b0);
        // Logic immediates zero-extend
        addEntry(encodeI(OpAndi, 5'd3, 5'd25, 16'h8000), 1'b1, 1'b0);
        addEntry(encodeI(OpXori, 5'd3, 5'd26, 16'h8000), 1'b1, 1'b0);
        addEntry(encodeR(5'd1, 5'd3, 5'd5, 5'd0, FnAddu), 1'b1, 1'b0);
        addEntry(encodeR(5'd1, 5'd2, 5'd6, 5'd0, FnSubu), 1'b1, 1'b0);
        addEntry(encodeR(5'd2, 5'd3, 5'd7, 5'd0, FnAnd), 1'b1, 1'b0);
        addEntry(encodeR(5'd1, 5'd2, 5'd8, 5'd0, FnOr), 1'b1, 1'b0);
        addEntry(encodeR(5'd1, 5'd3, 5'd9, 5'd0, FnXor), 1'b1, 1'b0);
        addEntry(encodeR(5'd1, 5'd0, 5'd10, 5'd0, FnNor), 1'b1, 1'b0);
        // -1 against a positive value, signed and unsigned
        addEntry(encodeR(5'd3, 5'd1, 5'd11, 5'd0, FnSlt), 1'b1, 1'b0);
        addEntry(encodeR(5'd3, 5'd1, 5'd12, 5'd0, FnSltu), 1'b1, 1'b0);
        // Shifts of 0x80000001 by 0, 1 and 31
        addEntry(encodeR(5'd0, 5'd2, 5'd14, 5'd0, FnSll), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd15, 5'd1, FnSll), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd16, 5'd31, FnSll), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd17, 5'd0, FnSrl), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd18, 5'd1, FnSrl), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd19, 5'd31, FnSrl), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd20, 5'd0, FnSra), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd21, 5'd1, FnSra), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd2, 5'd22, 5'd31, FnSra), 1'b1, 1'b0);
        // Register 0 as destination and as source
        addEntry(encodeR(5'd1, 5'd1, 5'd0, 5'd0, FnAddu), 1'b1, 1'b0);
        addEntry(encodeR(5'd0, 5'd1, 5'd23, 5'd0, FnOr), 1'b1, 1'b0);
        // Unknown opcode, unknown funct, then a write without valid
        addEntry(encodeI(6'h3F, 5'd3, 5'd1, 16'hFFFF), 1'b1, 1'b1);
        addEntry(encodeR(5'd1, 5'd1, 5'd5, 5'd0, 6'h3F), 1'b1, 1'b1);
        addEntry(encodeI(OpOri, 5'd0, 5'd24, 16'hBEEF), 1'b0, 1'b0);
    endtask

    //------------------------------------------------------------------
    // Reference model of one instruction
    //------------------------------------------------------------------
    task automatic applyModel(input logic [31:0] w, input logic valid, output logic [4:0] dest);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        logic        ok;
        a    = model[w[25:21]];
        b    = model[w[20:16]];
        sx   = {{16{w[15]}}, w[15:0]};
        zx   = {16'h0000, w[15:0]};
        res  = '0;
        ok   = 1'b1;
        // rd for R-type, rt otherwise
        dest = (w[31:26] == OpSpecial) ? w[15:11] : w[20:16];
        if (w[31:26] == OpSpecial)
        begin
            case (w[5:0])
                FnAddu:  res = a + b;
                FnSubu:  res = a - b;
                FnAnd:   res = a & b;
                FnOr:    res = a | b;
                FnXor:   res = a ^ b;
                FnNor:   res = ~(a | b);
                FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FnSltu:  res = (a < b) ? 32'd1 : 32'd0;
                FnSll:   res = b << w[10:6];
                FnSrl:   res = b >> w[10:6];
                FnSra:   res = $signed(b) >>> w[10:6];
                default: ok = 1'b0;
            endcase
        end
        else
        begin
            case (w[31:26])
                OpAddiu: res = a + sx;
                OpSlti:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                OpAndi:  res = a & zx;
                OpOri:   res = a | zx;
                OpXori:  res = a ^ zx;
                OpLui:   res = {w[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
        if (valid && ok && dest != 5'd0)
            model[dest] = res;
    endtask

    //------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------
    task automatic checkIllegal(input logic expected);
        if (Illegal !== expected)
        begin
            $display("mismatch at %0t: Illegal expected %b got %b", $time, expected, Illegal);
            errors++;
        end
    endtask

    task automatic checkRegister(input logic [4:0] addr);
        DbgAddr = addr;
        #1;
        if (DbgData !== model[addr])
        begin
            $display("mismatch at %0t: DbgData[%0d] expected %h got %h",
                     $time, addr, model[addr], DbgData);
            errors++;
        end
    endtask

    // Whole file through the debug port
    task automatic sweepRegisters;
        for (int k = 0; k < 32; k++)
            checkRegister(5'(k));
    endtask

    task automatic waitForReset(output logic released);
        int cycles;
        cycles = 0;
        while (nReset !== 1'b1 && cycles < 20)
        begin
            @(posedge Clock);
            cycles++;
        end
        released = (nReset === 1'b1);
    endtask

    task automatic runTests;
        logic [4:0] dest;
        // Clean state after reset
        @(posedge Clock);
        #5;
        checkIllegal(1'b0);
        sweepRegisters();
        for (int i = 0; i < instrQ.size(); i++)
        begin
            @(posedge Clock);
            #5;
            Instr      = instrQ[i];
            InstrValid = validQ[i];
            // Illegal is combinational in the same cycle
            #40;
            checkIllegal(illegalQ[i]);
            applyModel(instrQ[i], validQ[i], dest);
            // Result visible one edge later
            @(posedge Clock);
            #5;
            InstrValid = 1'b0;
            Instr      = '0;
            checkRegister(dest);
        end
        // Nothing else moved
        sweepRegisters();
    endtask

    //------------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------------
    initial
    begin
        logic released;
        Instr      = '0;
        InstrValid = 1'b0;
        DbgAddr    = '0;
        errors     = 0;
        for (int k = 0; k < 32; k++)
            model[k] = '0;
        buildTable();
        waitForReset(released);
        if (!released)
        begin
            $display("reset was not released within 20 cycles");
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            runTests();
            $display("checks done, %0d errors", errors);
            if (errors == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

endmodule

/* vlog.f */
mipsPkg.sv
registers.sv
instrDecode.sv
alu.sv
mipsCore.sv
mipsCore_tb.sv

/* Makefile */
# Verilator flow for the MIPS execute core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module mipsCore_tb -o simv

run: compile
	obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation ended early"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
